// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing -Wno-fatal
TOP = tb_cache_sim
FILELIST = cache_sim.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/cache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_checker import cache_pkg::*; (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_req_valid,
	input wire logic i_req_ready,
	input wire stats_t i_exp_stats,
	input wire logic [7:0] i_group,
	input wire stats_t i_stats,
	input wire logic i_done,
	output int o_checks,
	output int o_errors
);

	// One request in flight at most
	logic pending;
	logic in_access;
	logic reported;
	stats_t exp_held;
	int active_group;
	int group_checks;
	int group_errors;

	task automatic compare_field(input string name, input logic [`STAT_BITS-1:0] got,
		input logic [`STAT_BITS-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: request %0d, %s is %0d, expected %0d",
				$time, o_checks + 1, name, got, exp);
			o_errors++;
			group_errors++;
		end
	endtask

	// Handshake level seen at the wrong cycle
	task automatic report_ready_error(input string what);
		$display("[ERROR] %0t: request %0d, %s", $time, o_checks + 1, what);
		o_errors++;
		group_errors++;
	endtask

	// Summary of the group that just finished
	task automatic close_group();
		if (active_group >= 0) begin
			$display("test %0d: %0d requests checked, %0d errors",
				active_group, group_checks, group_errors);
		end
	endtask

	// Sampled at the falling edge between input changes
	always @(negedge i_clk) begin
		if (i_reset) begin
			pending = 1'b0;
			in_access = 1'b0;
			reported = 1'b0;
			active_group = -1;
			group_checks = 0;
			group_errors = 0;
			o_checks = 0;
			o_errors = 0;
		end else begin
			if (pending) begin
				if (!in_access) begin
					// First falling edge after acceptance sits in the ACCESS cycle
					if (i_req_ready) begin
						report_ready_error("ready is high in the access cycle");
					end
					in_access = 1'b1;
				end else begin
					// Ready back means the stats already hold the result
					if (!i_req_ready) begin
						report_ready_error("ready is still low one cycle after acceptance");
					end
					compare_field("d_reads", i_stats.d_reads, exp_held.d_reads);
					compare_field("d_writes", i_stats.d_writes, exp_held.d_writes);
					compare_field("d_hits", i_stats.d_hits, exp_held.d_hits);
					compare_field("d_misses", i_stats.d_misses, exp_held.d_misses);
					compare_field("i_fetches", i_stats.i_fetches, exp_held.i_fetches);
					compare_field("i_hits", i_stats.i_hits, exp_held.i_hits);
					compare_field("i_misses", i_stats.i_misses, exp_held.i_misses);
					group_checks++;
					o_checks++;
					pending = 1'b0;
				end
			end
			// Acceptance at the coming edge
			if (i_req_valid && i_req_ready) begin
				if (int'(i_group) != active_group) begin
					close_group();
					active_group = int'(i_group);
					group_checks = 0;
					group_errors = 0;
				end
				pending = 1'b1;
				in_access = 1'b0;
				exp_held = i_exp_stats;
			end
			if (i_done && !reported) begin
				close_group();
				$display("all tests: %0d requests checked, %0d errors", o_checks, o_errors);
				reported = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/cache_sim_golden.txt ====
# group(dec) cmd(hex) addr(hex), then counts after the request (dec):
# d_reads d_writes d_hits d_misses i_fetches i_hits i_misses
1 0 00000000 1 0 0 1 0 0 0
1 1 00000040 1 1 0 2 0 0 0
1 0 00000400 2 1 0 3 0 0 0
1 0 00000010 3 1 1 3 0 0 0
1 1 00000000 3 2 2 3 0 0 0
1 0 00000044 4 2 3 3 0 0 0
1 1 00000404 4 3 4 3 0 0 0
# Set 2, tags 0x10 to 0x18
2 0 00004080 5 3 4 4 0 0 0
2 1 00004480 5 4 4 5 0 0 0
2 0 00004880 6 4 4 6 0 0 0
2 1 00004c80 6 5 4 7 0 0 0
2 0 00005080 7 5 4 8 0 0 0
2 1 00005480 7 6 4 9 0 0 0
2 0 00005880 8 6 4 10 0 0 0
2 1 00005c80 8 7 4 11 0 0 0
2 0 00004080 9 7 5 11 0 0 0
2 1 00006080 9 8 5 12 0 0 0
2 0 00004480 10 8 5 13 0 0 0
2 0 00004080 11 8 6 13 0 0 0
2 1 00006080 11 9 7 13 0 0 0
# Instruction bank, set 3, tags 0x20 to 0x24
3 2 000080c0 11 9 7 13 1 0 1
3 2 000084c0 11 9 7 13 2 0 2
3 2 000088c0 11 9 7 13 3 0 3
3 2 00008cc0 11 9 7 13 4 0 4
3 2 000080c0 11 9 7 13 5 1 4
3 2 000090c0 11 9 7 13 6 1 5
3 2 000084c0 11 9 7 13 7 1 6
3 2 000080c0 11 9 7 13 8 2 6
3 0 000080c0 12 9 7 14 8 2 6
3 2 000080c0 12 9 7 14 9 3 6
3 2 00000000 12 9 7 14 10 3 7
# Clear, then cold misses again
4 8 00000000 0 0 0 0 0 0 0
4 0 00000000 1 0 0 1 0 0 0
4 2 000080c0 1 0 0 1 1 0 1
4 1 00004080 1 1 0 2 1 0 1
4 0 00000000 2 1 1 2 1 0 1
# Unknown codes change nothing
5 3 00010000 2 1 1 2 1 0 1
5 9 00004080 2 1 1 2 1 0 1
5 f ffffffc0 2 1 1 2 1 0 1
5 5 00000000 2 1 1 2 1 0 1
5 0 00010000 3 1 1 3 1 0 1
5 2 000080c0 3 1 1 3 2 1 1

// ==== bench/tb_cache_sim.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_cache_sim import cache_pkg::*; ();

	logic i_clk;
	logic i_reset;
	logic i_req_valid;
	trace_req_t i_req;
	logic o_req_ready;
	stats_t o_stats;

	// Expected counts and group travel with the request
	stats_t exp_stats;
	logic [7:0] cur_group;
	logic run_done;
	int checks;
	int errors;

	// Golden lines
	trace_req_t req_q[$];
	stats_t exp_q[$];
	logic [7:0] group_q[$];
	int n_req;
	int cycles;
	int cycle_limit;
	int gap;

	cache_sim_top DUT (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_req_valid(i_req_valid),
		.i_req(i_req),
		.o_req_ready(o_req_ready),
		.o_stats(o_stats)
	);

	cache_checker u_checker (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_req_valid(i_req_valid),
		.i_req_ready(o_req_ready),
		.i_exp_stats(exp_stats),
		.i_group(cur_group),
		.i_stats(o_stats),
		.i_done(run_done),
		.o_checks(checks),
		.o_errors(errors)
	);

	// 4 ns clock
	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// Parse group, command, address and seven counts per line
	task automatic load_golden();
		int fd;
		int n;
		string line;
		int grp;
		int cmd;
		int addr;
		int c0, c1, c2, c3, c4, c5, c6;
		trace_req_t req;
		stats_t s;
		fd = $fopen("bench/cache_sim_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the golden file bench/cache_sim_golden.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%d %h %h %d %d %d %d %d %d %d",
					grp, cmd, addr, c0, c1, c2, c3, c4, c5, c6);
				// Comment and blank lines fall through here
				if (n == 10) begin
					req.cmd = cmd_t'(cmd);
					req.addr = `ADDR_BITS'(addr);
					s.d_reads = `STAT_BITS'(c0);
					s.d_writes = `STAT_BITS'(c1);
					s.d_hits = `STAT_BITS'(c2);
					s.d_misses = `STAT_BITS'(c3);
					s.i_fetches = `STAT_BITS'(c4);
					s.i_hits = `STAT_BITS'(c5);
					s.i_misses = `STAT_BITS'(c6);
					req_q.push_back(req);
					exp_q.push_back(s);
					group_q.push_back(8'(grp));
				end
			end
			$fclose(fd);
		end
		n_req = req_q.size();
	endtask

	// Hold valid until the DUT takes the request
	task automatic send_request(input int idx);
		i_req_valid = 1'b1;
		i_req = req_q[idx];
		exp_stats = exp_q[idx];
		cur_group = group_q[idx];
		while (!o_req_ready) begin
			@(posedge i_clk);
			#1;
		end
		@(posedge i_clk);
		#1;
	endtask

	// Cycle budget scales with the trace length
	always @(posedge i_clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, %0d of %0d requests checked",
				cycles, checks, n_req);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		i_reset = 1'b1;
		i_req_valid = 1'b0;
		i_req = '0;
		exp_stats = '0;
		cur_group = '0;
		run_done = 1'b0;
		cycles = 0;
		cycle_limit = 0;
		void'($urandom(32'h06864fe8));
		load_golden();
		cycle_limit = n_req * 6 + 50;
		if (n_req == 0) begin
			$display("The golden file holds no requests");
		end
		repeat (3) @(posedge i_clk);
		#1;
		i_reset = 1'b0;
		for (int i = 0; i < n_req; i++) begin
			send_request(i);
			// Zero gap keeps valid high into the next request
			gap = int'($urandom % 4);
			if (gap != 0) begin
				i_req_valid = 1'b0;
				repeat (gap) begin
					@(posedge i_clk);
					#1;
				end
			end
		end
		i_req_valid = 1'b0;
		// Last result lands two edges after acceptance
		while (checks < n_req) begin
			@(posedge i_clk);
			#1;
		end
		run_done = 1'b1;
		@(negedge i_clk);
		#1;
		if (n_req > 0 && checks == n_req && errors == 0) begin
			$display("TEST OK");
		end else begin
			if (checks != n_req || n_req == 0) begin
				$display("Only %0d of %0d requests were checked", checks, n_req);
			end
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== cache_sim.f ====
+incdir+rtl
rtl/cache_pkg.sv
rtl/trace_sequencer.sv
rtl/lru_ranker.sv
rtl/tag_store.sv
rtl/access_counters.sv
rtl/cache_sim_top.sv
bench/cache_checker.sv
bench/tb_cache_sim.sv

// ==== rtl/access_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_counters import cache_pkg::*; (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire access_t i_access,
	input wire logic i_d_hit,
	input wire logic i_i_hit,
	output stats_t o_stats
);

	// Reads and writes share the data hit/miss counts
	logic d_any;

	assign d_any = i_access.d_read || i_access.d_write;

	always_ff @(posedge i_clk) begin
		if (i_reset || i_access.clear) begin
			o_stats <= '0;
		end else begin
			// Per-command counts
			if (i_access.d_read) begin
				o_stats.d_reads <= o_stats.d_reads + 1'b1;
			end
			if (i_access.d_write) begin
				o_stats.d_writes <= o_stats.d_writes + 1'b1;
			end
			if (i_access.i_fetch) begin
				o_stats.i_fetches <= o_stats.i_fetches + 1'b1;
			end
			// Data bank outcome
			if (d_any) begin
				if (i_d_hit) begin
					o_stats.d_hits <= o_stats.d_hits + 1'b1;
				end else begin
					o_stats.d_misses <= o_stats.d_misses + 1'b1;
				end
			end
			// Instruction bank outcome
			if (i_access.i_fetch) begin
				if (i_i_hit) begin
					o_stats.i_hits <= o_stats.i_hits + 1'b1;
				end else begin
					o_stats.i_misses <= o_stats.i_misses + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Trace address split
`define ADDR_BITS 32
`define OFFSET_BITS 6
`define INDEX_BITS 4
`define SETS 16

// Associativity per bank
`define D_WAYS 8
`define I_WAYS 4

// Tags take whatever sits above index and offset
`define D_TAG_BITS (`ADDR_BITS - `INDEX_BITS - `OFFSET_BITS)
`define I_TAG_BITS (`ADDR_BITS - `INDEX_BITS - `OFFSET_BITS)

// Trace command codes
`define CMD_READ 4'd0
`define CMD_WRITE 4'd1
`define CMD_IFETCH 4'd2
`define CMD_CLEAR 4'd8

// Width of each statistic
`define STAT_BITS 16

`endif

// ==== rtl/cache_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

	// Raw trace command, unknown codes allowed
	typedef logic [3:0] cmd_t;

	// One trace line as seen at the input
	typedef struct packed {
		cmd_t cmd;
		logic [`ADDR_BITS-1:0] addr;
	} trace_req_t;

	// Tags per bank
	typedef logic [`D_TAG_BITS-1:0] d_tag_t;
	typedef logic [`I_TAG_BITS-1:0] i_tag_t;

	// One-hot strobes for the ACCESS cycle
	typedef struct packed {
		logic d_read;
		logic d_write;
		logic i_fetch;
		logic clear;
	} access_t;

	// Statistics as seen at the top
	typedef struct packed {
		logic [`STAT_BITS-1:0] d_reads;
		logic [`STAT_BITS-1:0] d_writes;
		logic [`STAT_BITS-1:0] d_hits;
		logic [`STAT_BITS-1:0] d_misses;
		logic [`STAT_BITS-1:0] i_fetches;
		logic [`STAT_BITS-1:0] i_hits;
		logic [`STAT_BITS-1:0] i_misses;
	} stats_t;

endpackage

`default_nettype wire

// ==== rtl/cache_sim_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_sim_top import cache_pkg::*; (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_req_valid,
	input wire trace_req_t i_req,
	output logic o_req_ready,
	output stats_t o_stats
);

	logic [`ADDR_BITS-1:0] addr;
	access_t access;
	logic [`INDEX_BITS-1:0] index;
	d_tag_t d_tag;
	i_tag_t i_tag;
	logic d_access;
	logic d_hit;
	logic i_hit;
	logic [$clog2(`D_WAYS)-1:0] d_victim_way;
	logic [$clog2(`D_WAYS)-1:0] d_way;
	logic [$clog2(`I_WAYS)-1:0] i_victim_way;
	logic [$clog2(`I_WAYS)-1:0] i_way;

	// Address split, offset bits dropped
	assign index = addr[`OFFSET_BITS +: `INDEX_BITS];
	assign d_tag = addr[`ADDR_BITS-1 -: `D_TAG_BITS];
	assign i_tag = addr[`ADDR_BITS-1 -: `I_TAG_BITS];

	// Reads and writes both hit the data bank
	assign d_access = access.d_read | access.d_write;

	trace_sequencer u_seq (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_req_valid(i_req_valid),
		.i_req(i_req),
		.o_req_ready(o_req_ready),
		.o_addr(addr),
		.o_access(access)
	);

	// Data bank, 8 ways
	lru_ranker #(.WAYS(`D_WAYS)) u_d_lru (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_clear(access.clear),
		.i_index(index),
		.i_touch(d_access),
		.i_touch_way(d_way),
		.o_victim_way(d_victim_way)
	);

	tag_store #(.TAG_T(d_tag_t), .WAYS(`D_WAYS)) u_d_tags (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_clear(access.clear),
		.i_access(d_access),
		.i_index(index),
		.i_tag(d_tag),
		.i_victim_way(d_victim_way),
		.o_hit(d_hit),
		.o_way(d_way)
	);

	// Instruction bank, 4 ways
	lru_ranker #(.WAYS(`I_WAYS)) u_i_lru (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_clear(access.clear),
		.i_index(index),
		.i_touch(access.i_fetch),
		.i_touch_way(i_way),
		.o_victim_way(i_victim_way)
	);

	tag_store #(.TAG_T(i_tag_t), .WAYS(`I_WAYS)) u_i_tags (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_clear(access.clear),
		.i_access(access.i_fetch),
		.i_index(index),
		.i_tag(i_tag),
		.i_victim_way(i_victim_way),
		.o_hit(i_hit),
		.o_way(i_way)
	);

	access_counters u_counters (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_access(access),
		.i_d_hit(d_hit),
		.i_i_hit(i_hit),
		.o_stats(o_stats)
	);

endmodule

`default_nettype wire

// ==== rtl/lru_ranker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module lru_ranker import cache_pkg::*; #(
	parameter int WAYS = `D_WAYS
) (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_clear,
	input wire logic [`INDEX_BITS-1:0] i_index,
	input wire logic i_touch,
	input wire logic [$clog2(WAYS)-1:0] i_touch_way,
	output logic [$clog2(WAYS)-1:0] o_victim_way
);

	localparam int WAY_BITS = $clog2(WAYS);

	// Rank 0 is least recent and WAYS-1 most recent
	logic [WAY_BITS-1:0] rank_q [`SETS][WAYS];
	logic [WAY_BITS-1:0] touched_rank;

	// Current rank of the way being touched
	assign touched_rank = rank_q[i_index][i_touch_way];

	// Victim is whichever way sits at rank 0
	always_comb begin
		o_victim_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (rank_q[i_index][w] == '0) begin
				o_victim_way = WAY_BITS'(w);
			end
		end
	end

	// Rank update on touch
	always_ff @(posedge i_clk) begin
		if (i_reset || i_clear) begin
			// Start with rank equal to way number
			for (int s = 0; s < `SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					rank_q[s][w] <= WAY_BITS'(w);
				end
			end
		end else if (i_touch) begin
			for (int w = 0; w < WAYS; w++) begin
				if (w == int'(i_touch_way)) begin
					// Touched way becomes MRU
					rank_q[i_index][w] <= WAY_BITS'(WAYS - 1);
				end else if (rank_q[i_index][w] > touched_rank) begin
					// Ways above it slide down one
					rank_q[i_index][w] <= rank_q[i_index][w] - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tag_store import cache_pkg::*; #(
	parameter type TAG_T = d_tag_t,
	parameter int WAYS = `D_WAYS
) (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_clear,
	input wire logic i_access,
	input wire logic [`INDEX_BITS-1:0] i_index,
	input wire TAG_T i_tag,
	input wire logic [$clog2(WAYS)-1:0] i_victim_way,
	output logic o_hit,
	output logic [$clog2(WAYS)-1:0] o_way
);

	localparam int WAY_BITS = $clog2(WAYS);

	// Tag array, contents only meaningful where valid
	TAG_T tag_q [`SETS][WAYS];
	logic [`SETS-1:0][WAYS-1:0] valid_q;
	logic [WAY_BITS-1:0] hit_way;
	logic fill;

	// Parallel compare over the set
	always_comb begin
		o_hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (valid_q[i_index][w] && (tag_q[i_index][w] == i_tag)) begin
				o_hit = 1'b1;
				hit_way = WAY_BITS'(w);
			end
		end
	end

	// Hit way, or the LRU victim on a miss
	assign o_way = o_hit ? hit_way : i_victim_way;

	// Allocate only on a miss
	assign fill = i_access && !o_hit;

	// Valid bits
	always_ff @(posedge i_clk) begin
		if (i_reset || i_clear) begin
			valid_q <= '0;
		end else if (fill) begin
			valid_q[i_index][o_way] <= 1'b1;
		end
	end

	// Tag write into the chosen way
	always_ff @(posedge i_clk) begin
		if (fill) begin
			tag_q[i_index][o_way] <= i_tag;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/trace_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module trace_sequencer import cache_pkg::*; (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_req_valid,
	input wire trace_req_t i_req,
	output logic o_req_ready,
	output logic [`ADDR_BITS-1:0] o_addr,
	output access_t o_access
);

	// IDLE waits for a request, ACCESS lets the banks work for one cycle
	typedef enum logic {
		IDLE,
		ACCESS
	} state_t;

	state_t state_q;
	logic accept;
	logic [`ADDR_BITS-1:0] addr_q;
	access_t access_q;

	// Ready only while idle
	assign o_req_ready = (state_q == IDLE);
	assign accept = i_req_valid && o_req_ready;

	// State register
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: begin
					if (accept) begin
						state_q <= ACCESS;
					end
				end
				ACCESS: begin
					// Always back to idle after one cycle
					state_q <= IDLE;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// Strobes live for the ACCESS cycle only
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			access_q <= '0;
		end else begin
			access_q <= '0;
			if (accept) begin
				case (i_req.cmd)
					`CMD_READ: access_q.d_read <= 1'b1;
					`CMD_WRITE: access_q.d_write <= 1'b1;
					`CMD_IFETCH: access_q.i_fetch <= 1'b1;
					`CMD_CLEAR: access_q.clear <= 1'b1;
					// Anything else is swallowed
					default: access_q <= '0;
				endcase
			end
		end
	end

	// Held address for the banks
	always_ff @(posedge i_clk) begin
		if (accept) begin
			addr_q <= i_req.addr;
		end
	end

	assign o_addr = addr_q;
	assign o_access = access_q;

endmodule

`default_nettype wire
